/* weight_update.f */
hw/wu_pkg.sv
hw/mem_wr_if.sv
hw/sync_fifo.sv
hw/slice_walker.sv
hw/mem_port.sv
hw/update_lanes.sv
hw/write_back.sv
hw/weight_update.sv
verif/tb_mem_model.sv
verif/tb_weight_update.sv

/* Makefile */
TB_TOP  = tb_weight_update
RTL_TOP = weight_update
LOG     = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f weight_update.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f weight_update.f \
		--top-module $(TB_TOP) -Mdir obj_dir -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verif/tb_weight_update.sv */
// testbench for the weight updater
//   clock, reset, an init pass and a plain update pass
//   reference memory, slice order and lane update rule
//   assertions on memory traffic, result stream and handshakes
//   cycle limit and error summary
`timescale 1ns/100ps

module tb_weight_update
   import wu_pkg::*;
();

   localparam int TOTAL_LEN = 48;
   localparam int NODE_ID   = 1;
   localparam int NUM_NODE  = 3;
   localparam int MEM_AW    = 6;
   localparam int MEM_WORDS = 1 << MEM_AW;
   // init stream plus two update passes, 40 cycles per word
   localparam int MAX_CYCLES = 40 * 3 * TOTAL_LEN;

   logic  clk;
   logic  reset;
   logic  cmd_valid;
   logic  cmd_init;
   logic  cmd_ready;
   word_t weight_in;
   logic  weight_valid;
   logic  weight_ready;
   word_t gradient_in;
   logic  gradient_valid;
   logic  gradient_ready;
   word_t result_out;
   logic  result_valid;
   logic  result_ready = 1'b0;
   len_t  total_length;
   node_t node_id;
   node_t num_node;
   addr_t avs_address;
   word_t avs_writedata;
   logic  avs_read;
   logic  avs_write;
   word_t avs_readdata;
   logic  avs_waitrequest;
   logic  avs_readdatavalid;
   logic  mem_stall = 1'b0;

   logic [31:0] data_seed = 32'd13930;
   // noise stream runs on the inverted seed
   logic [31:0] noise_seed = ~32'd13930;

   int    errors = 0;
   int    cycles = 0;
   int    exp_addr [TOTAL_LEN];
   word_t ref_mem [MEM_WORDS];
   word_t grad_q [$];
   addr_t wr_addr_q [$];
   word_t wr_data_q [$];
   int    init_idx = 0;
   int    rd_idx = 0;
   int    res_idx = 0;

   assign total_length = len_t'(TOTAL_LEN);
   assign node_id      = node_t'(NODE_ID);
   assign num_node     = node_t'(NUM_NODE);

   weight_update i_dut (.*);

   tb_mem_model #(.MEM_AW(MEM_AW)) i_mem (
      .clk, .reset, .stall (mem_stall),
      .avs_address, .avs_writedata, .avs_read, .avs_write,
      .avs_readdata, .avs_waitrequest, .avs_readdatavalid
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic word_t random_word();
      word_t w;
      for (int i = 0; i < 2; i++) begin
         data_seed = lcg_step(data_seed);
         w[i*32 +: 32] = data_seed;
      end
      return w;
   endfunction

   // roughly one idle input cycle in four
   function automatic logic random_gap();
      data_seed = lcg_step(data_seed);
      return data_seed[31:30] == 2'b00;
   endfunction

   // new lane = weight - gradient / 2^LR_SHIFT rounded down, modulo the lane width
   function automatic word_t expect_update(input word_t w, input word_t g);
      word_t r;
      lane_t wl;
      lane_t gl;
      int    wi;
      int    gi;
      for (int i = 0; i < LANES; i++) begin
         wl = w[i*LANE_W +: LANE_W];
         gl = g[i*LANE_W +: LANE_W];
         wi = wl;
         gi = gl;
         r[i*LANE_W +: LANE_W] = LANE_W'(wi - (gi >>> LR_SHIFT));
      end
      return r;
   endfunction

   // slices after our own node come first, our own slice closes each block
   task automatic build_order();
      int n;
      int sl;
      n = 0;
      for (int base = 0; base < TOTAL_LEN; base += NUM_NODE * SLICE_WORDS) begin
         for (int s = 1; s <= NUM_NODE; s++) begin
            sl = (NODE_ID + s) % NUM_NODE;
            for (int w = 0; w < SLICE_WORDS; w++) begin
               exp_addr[n] = base + sl * SLICE_WORDS + w;
               n++;
            end
         end
      end
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
      errors++;
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, expected, actual);
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   task automatic print_counts();
      $display("errors: %0d, results: %0d, reads: %0d", errors, res_idx, rd_idx);
   endtask

   ////////////////////////////////////////////////////////////////////
   // stimulus streams, held stable until accepted
   ////////////////////////////////////////////////////////////////////
   task automatic stream_weights();
      for (int k = 0; k < TOTAL_LEN; k++) begin
         if (random_gap()) @(negedge clk);
         weight_in    = random_word();
         weight_valid = 1'b1;
         do @(posedge clk); while (!weight_ready);
         @(negedge clk);
         weight_valid = 1'b0;
      end
   endtask

   task automatic stream_gradients();
      for (int k = 0; k < TOTAL_LEN; k++) begin
         if (random_gap()) @(negedge clk);
         gradient_in    = random_word();
         gradient_valid = 1'b1;
         do @(posedge clk); while (!gradient_ready);
         @(negedge clk);
         gradient_valid = 1'b0;
      end
   endtask

   task automatic run_pass(input logic init, input int pass_no);
      @(negedge clk);
      cmd_valid = 1'b1;
      cmd_init  = init;
      do @(posedge clk); while (!cmd_ready);
      @(negedge clk);
      cmd_valid = 1'b0;
      cmd_init  = 1'b0;
      fork
         if (init) stream_weights();
         stream_gradients();
      join
      // cmd_ready comes back once the last word is written
      do @(posedge clk); while (!cmd_ready);
      @(negedge clk);
      while (wr_addr_q.size() != 0) @(negedge clk);
      a_pass_results: assert (res_idx == pass_no * TOTAL_LEN)
         else report_error($sformatf("pass %0d gave %0d results in total", pass_no, res_idx));
      a_pass_reads: assert (rd_idx == pass_no * TOTAL_LEN)
         else report_error($sformatf("pass %0d issued %0d reads in total", pass_no, rd_idx));
      a_grad_used: assert (grad_q.size() == 0)
         else report_error("accepted gradients left without a result");
   endtask

   // memory stall and result back-pressure
   always @(negedge clk) begin
      noise_seed   = lcg_step(noise_seed);
      mem_stall    = (noise_seed[30:29] == 2'b00);
      result_ready = (noise_seed[27:26] != 2'b00);
   end

   ////////////////////////////////////////////////////////////////////
   // monitor and reference model
   ////////////////////////////////////////////////////////////////////
   always @(posedge clk) begin
      if (!reset) begin
         // init stream, k-th weight belongs at address k
         if (weight_valid && weight_ready) begin
            ref_mem[init_idx] = weight_in;
            wr_addr_q.push_back(addr_t'(init_idx));
            wr_data_q.push_back(weight_in);
            init_idx++;
         end
         if (gradient_valid && gradient_ready) begin
            grad_q.push_back(gradient_in);
         end
         if (avs_read && !avs_waitrequest) begin
            a_rd_addr: assert (avs_address == addr_t'(exp_addr[rd_idx % TOTAL_LEN]))
               else report_mismatch("avs_address", 64'(exp_addr[rd_idx % TOTAL_LEN]),
                                    64'(avs_address));
            rd_idx++;
         end
         if (result_valid && result_ready) begin
            if (grad_q.size() == 0) begin
               report_error("result appeared with no gradient accepted for it");
            end else begin
               update_reference(exp_addr[res_idx % TOTAL_LEN], grad_q.pop_front());
            end
            res_idx++;
         end
         // memory writes come out in request order
         if (avs_write && !avs_waitrequest) begin
            if (wr_addr_q.size() == 0) begin
               report_error("memory write with no pending write request");
            end else begin
               a_wr_addr: assert (avs_address == wr_addr_q[0])
                  else report_mismatch("avs_address", 64'(wr_addr_q[0]), 64'(avs_address));
               a_wr_data: assert (avs_writedata == wr_data_q[0])
                  else report_mismatch("avs_writedata", wr_data_q[0], avs_writedata);
               void'(wr_addr_q.pop_front());
               void'(wr_data_q.pop_front());
            end
         end
      end
   end

   // expected result for one slice word, which is also its write-back
   task automatic update_reference(input int a, input word_t g);
      word_t exp_w;
      exp_w = expect_update(ref_mem[a], g);
      a_result: assert (result_out == exp_w)
         else report_mismatch("result_out", exp_w, result_out);
      ref_mem[a] = exp_w;
      wr_addr_q.push_back(addr_t'(a));
      wr_data_q.push_back(exp_w);
   endtask

   a_one_strobe: assert property (@(posedge clk) disable iff (reset)
      !(avs_read && avs_write))
      else report_error("avs_read and avs_write high in the same cycle");

   // stalled result holds word and valid
   a_result_hold: assert property (@(posedge clk) disable iff (reset)
      (result_valid && !result_ready) |=> (result_valid && $stable(result_out)))
      else report_error("result stream changed while result_ready was low");

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         errors++;
         $display("timeout after %0d cycles, a handshake never completed", cycles);
         print_counts();
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////
   initial begin
      reset          = 1'b1;
      cmd_valid      = 1'b0;
      cmd_init       = 1'b0;
      weight_in      = '0;
      weight_valid   = 1'b0;
      gradient_in    = '0;
      gradient_valid = 1'b0;
      build_order();
      repeat (10) @(posedge clk);
      @(negedge clk);
      a_reset_quiet: assert (!avs_read && !avs_write && !result_valid && !weight_ready &&
                             !gradient_ready && !cmd_ready)
         else report_error("outputs not low at the end of reset");
      reset = 1'b0;
      for (int a = 0; a < MEM_WORDS; a++) begin
         ref_mem[a] = i_mem.mem[a];
      end
      // one cycle later the FSM is idle and takes commands
      @(negedge clk);
      a_idle_ready: assert (cmd_ready)
         else report_mismatch("cmd_ready", 64'd1, 64'(cmd_ready));

      run_pass(1'b1, 1);
      run_pass(1'b0, 2);

      for (int a = 0; a < MEM_WORDS; a++) begin
         a_mem_final: assert (i_mem.mem[a] == ref_mem[a])
            else report_mismatch($sformatf("mem[%0d]", a), ref_mem[a], i_mem.mem[a]);
      end

      print_counts();
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* verif/tb_mem_model.sv */
// behavioral memory behind the avs master ports
//   word-addressed array with an address-derived fill pattern
//   wait request taken from the testbench stall input
//   read data returns READ_LAT cycles after the accepted read
`timescale 1ns/100ps

module tb_mem_model
   import wu_pkg::*;
#(
   parameter int MEM_AW   = 6,
   parameter int READ_LAT = 2
) (
   input  logic  clk,
   input  logic  reset,
   input  logic  stall,
   input  addr_t avs_address,
   input  word_t avs_writedata,
   input  logic  avs_read,
   input  logic  avs_write,
   output word_t avs_readdata,
   output logic  avs_waitrequest,
   output logic  avs_readdatavalid
);

   localparam int MEM_WORDS = 1 << MEM_AW;

   word_t               mem [MEM_WORDS];
   word_t               data_pipe [READ_LAT];
   logic [READ_LAT-1:0] vld_pipe = '0;
   logic                rdv_q = 1'b0;
   word_t               rdata_q = '0;
   logic [MEM_AW-1:0]   idx;

   assign idx               = avs_address[MEM_AW-1:0];
   assign avs_waitrequest   = stall;
   assign avs_readdatavalid = rdv_q;
   assign avs_readdata      = rdata_q;

   // every lane differs and depends on the full word index
   initial begin
      for (int a = 0; a < MEM_WORDS; a++) begin
         for (int i = 0; i < LANES; i++) begin
            mem[a][i*LANE_W +: LANE_W] = LANE_W'(a * 40503 + i * 997 + 467);
         end
      end
   end

   // access completes on a cycle without wait request
   always @(posedge clk) begin
      if (avs_write && !avs_waitrequest) begin
         mem[idx] <= avs_writedata;
      end
      if (reset) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe <= {vld_pipe[READ_LAT-2:0], avs_read && !avs_waitrequest};
      end
      data_pipe[0] <= mem[idx];
      for (int s = 1; s < READ_LAT; s++) begin
         data_pipe[s] <= data_pipe[s-1];
      end
   end

   // response changes on the falling edge like every other dut input
   always @(negedge clk) begin
      rdv_q   = vld_pipe[READ_LAT-1];
      rdata_q = data_pipe[READ_LAT-1];
   end

endmodule

/* hw/weight_update.sv */
// weight updater top level
//   command writer, read address walker, memory master
//   response fifo, lane update pipeline, result fifo
`timescale 1ns/100ps

module weight_update
   import wu_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   // command stream
   input  logic  cmd_valid,
   input  logic  cmd_init,
   output logic  cmd_ready,
   // data streams
   input  word_t weight_in,
   input  logic  weight_valid,
   output logic  weight_ready,
   input  word_t gradient_in,
   input  logic  gradient_valid,
   output logic  gradient_ready,
   output word_t result_out,
   output logic  result_valid,
   input  logic  result_ready,
   // pass geometry
   input  len_t  total_length,
   input  node_t node_id,
   input  node_t num_node,
   // memory master
   output addr_t avs_address,
   output word_t avs_writedata,
   output logic  avs_read,
   output logic  avs_write,
   input  word_t avs_readdata,
   input  logic  avs_waitrequest,
   input  logic  avs_readdatavalid
);

   logic     pass_start;
   logic     rd_valid;
   logic     rd_req;
   logic     rd_ready;
   addr_t    rd_addr;
   word_t    rsp_data;
   logic     rsp_en;
   word_t    weight_data;
   logic     weight_take;
   logic     rsp_empty;
   rsp_lvl_t rsp_level;
   word_t    new_data;
   logic     new_en;
   word_t    result_data;
   logic     result_empty;
   logic     result_almfull;
   logic     result_take;

   mem_wr_if wr_if ();

   // reads wait while a result is offered, so the memory stays free for its write
   assign rd_req = rd_valid && !result_valid;

   write_back i_write_back (
      .clk (clk), .reset (reset),
      .cmd_valid (cmd_valid), .cmd_init (cmd_init), .cmd_ready (cmd_ready),
      .weight_in (weight_in), .weight_valid (weight_valid), .weight_ready (weight_ready),
      .result_data (result_data), .result_avail (!result_empty),
      .result_take (result_take), .result_ready (result_ready),
      .result_valid (result_valid), .result_out (result_out),
      .node_id (node_id), .num_node (num_node), .total_length (total_length),
      .pass_start (pass_start), .wr (wr_if.source)
   );

   // read side walk, one address per accepted read
   slice_walker i_rd_walker (
      .clk (clk), .reset (reset),
      .start (pass_start), .step (rd_req && rd_ready),
      .node_id (node_id), .num_node (num_node), .total_length (total_length),
      .addr_valid (rd_valid), .addr (rd_addr)
   );

   mem_port i_mem_port (
      .clk (clk), .reset (reset),
      .rd_valid (rd_req), .rd_addr (rd_addr), .rd_ready (rd_ready),
      .rsp_level (rsp_level), .rsp_data (rsp_data), .rsp_en (rsp_en),
      .wr (wr_if.sink),
      .avs_address (avs_address), .avs_writedata (avs_writedata),
      .avs_read (avs_read), .avs_write (avs_write), .avs_readdata (avs_readdata),
      .avs_waitrequest (avs_waitrequest), .avs_readdatavalid (avs_readdatavalid)
   );

   // stored weights waiting for their gradient
   sync_fifo #(.DW(WORD_W), .DEPTH(RSP_DEPTH), .ALMFULL(RSP_DEPTH)) rsp_fifo (
      .clk (clk), .reset (reset),
      .wr_data (rsp_data), .wr_en (rsp_en), .rd_en (weight_take),
      .rd_data (weight_data), .empty (rsp_empty), .full (),
      .level (rsp_level), .almfull ()
   );

   update_lanes i_update_lanes (
      .clk (clk), .reset (reset),
      .weight_data (weight_data), .weight_avail (!rsp_empty), .weight_take (weight_take),
      .gradient_in (gradient_in), .gradient_valid (gradient_valid),
      .gradient_ready (gradient_ready), .result_almfull (result_almfull),
      .new_data (new_data), .new_en (new_en)
   );

   // updated words waiting for write-back
   sync_fifo #(.DW(WORD_W), .DEPTH(RESULT_DEPTH), .ALMFULL(RESULT_ALMFULL)) result_fifo (
      .clk (clk), .reset (reset),
      .wr_data (new_data), .wr_en (new_en), .rd_en (result_take),
      .rd_data (result_data), .empty (result_empty), .full (),
      .level (), .almfull (result_almfull)
   );

endmodule

/* hw/write_back.sv */
// command FSM and write-back of updated weights
//   init phase streams weight_in to addresses 0 upward
//   update phase writes results back in slice order
//   each result goes to memory and out on the result stream together
`timescale 1ns/100ps

module write_back
   import wu_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      cmd_valid,
   input  logic      cmd_init,
   output logic      cmd_ready,
   input  word_t     weight_in,
   input  logic      weight_valid,
   output logic      weight_ready,
   input  word_t     result_data,
   input  logic      result_avail,
   output logic      result_take,
   input  logic      result_ready,
   output logic      result_valid,
   output word_t     result_out,
   input  node_t     node_id,
   input  node_t     num_node,
   input  len_t      total_length,
   output logic      pass_start,
   mem_wr_if.source  wr
);

   wb_state_t state;
   wb_state_t state_n;
   addr_t     init_addr;
   logic      cmd_rdy_q;
   logic      cmd_acc;
   logic      init_xfer;
   logic      init_last;
   logic      walk_valid;
   addr_t     walk_addr;

   // write-side address walk, mirrors the read walk
   slice_walker i_wr_walker (
      .clk          (clk),
      .reset        (reset),
      .start        (pass_start),
      .step         (result_take),
      .node_id      (node_id),
      .num_node     (num_node),
      .total_length (total_length),
      .addr_valid   (walk_valid),
      .addr         (walk_addr)
   );

   // registered so that it stays low in the first cycle out of reset
   assign cmd_ready = cmd_rdy_q;
   assign cmd_acc   = cmd_valid && cmd_ready;

   assign init_xfer    = (state == WB_INIT) && weight_valid && wr.ready;
   assign init_last    = init_xfer && (len_t'(init_addr) == total_length - 1);
   assign weight_ready = (state == WB_INIT) && wr.ready;

   // read pass begins right after accept or after the last init write
   assign pass_start = (cmd_acc && !cmd_init) || init_last;

   // offered once memory can take the word, held until the consumer takes it
   assign result_valid = (state == WB_UPDATE) && walk_valid && result_avail && wr.ready;
   // pop only when memory and the result consumer both take the word
   assign result_take  = result_valid && result_ready;
   assign result_out   = result_data;

   assign wr.valid = (state == WB_INIT) ? weight_valid : result_take;
   assign wr.addr  = (state == WB_INIT) ? init_addr : walk_addr;
   assign wr.data  = (state == WB_INIT) ? weight_in : result_data;

   ////////////////////////////////////////////////////////////////////
   // command FSM
   ////////////////////////////////////////////////////////////////////
   always_comb begin
      state_n = state;
      case (state)
         WB_IDLE: begin
            if (cmd_acc) state_n = cmd_init ? WB_INIT : WB_UPDATE;
         end
         WB_INIT: begin
            if (init_last) state_n = WB_UPDATE;
         end
         // walker drops valid once the last word is written
         WB_UPDATE: begin
            if (!walk_valid) state_n = WB_IDLE;
         end
         default: state_n = WB_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= WB_IDLE;
         cmd_rdy_q <= 1'b0;
         init_addr <= '0;
      end else begin
         state     <= state_n;
         cmd_rdy_q <= (state_n == WB_IDLE);
         if (cmd_acc) begin
            init_addr <= '0;
         end else if (init_xfer) begin
            init_addr <= init_addr + 1'b1;
         end
      end
   end

endmodule

/* hw/update_lanes.sv */
// gradient-descent update of one word
//   joins a stored weight word with a gradient word
//   new = weight - (gradient >>> LR_SHIFT) per signed lane
//   fixed UPDATE_LATENCY pipeline into the result fifo
`timescale 1ns/100ps

module update_lanes
   import wu_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  word_t weight_data,
   input  logic  weight_avail,
   output logic  weight_take,
   input  word_t gradient_in,
   input  logic  gradient_valid,
   output logic  gradient_ready,
   input  logic  result_almfull,
   output word_t new_data,
   output logic  new_en
);

   word_t                     upd_word;
   word_t                     data_pipe [UPDATE_LATENCY];
   logic [UPDATE_LATENCY-1:0] vld_pipe;
   logic                      take;

   function automatic lane_t lane_update(input lane_t w, input lane_t g);
      return w - (g >>> LR_SHIFT);
   endfunction

   // a gradient is only taken when its weight is already here
   assign gradient_ready = weight_avail && !result_almfull;
   assign take           = gradient_ready && gradient_valid;
   assign weight_take    = take;

   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         upd_word[i*LANE_W +: LANE_W] = lane_update(weight_data[i*LANE_W +: LANE_W],
                                                    gradient_in[i*LANE_W +: LANE_W]);
      end
   end

   // data pipe, never stalls
   always_ff @(posedge clk) begin
      data_pipe[0] <= upd_word;
      for (int s = 1; s < UPDATE_LATENCY; s++) begin
         data_pipe[s] <= data_pipe[s-1];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe <= {vld_pipe[UPDATE_LATENCY-2:0], take};
      end
   end

   assign new_data = data_pipe[UPDATE_LATENCY-1];
   assign new_en   = vld_pipe[UPDATE_LATENCY-1];

endmodule

/* hw/mem_port.sv */
// memory master with a single access in flight
//   write requests win over read requests
//   read credit from outstanding reads plus response fifo level
//   read data forwarded straight into the response fifo
`timescale 1ns/100ps

module mem_port
   import wu_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     rd_valid,
   input  addr_t    rd_addr,
   output logic     rd_ready,
   input  rsp_lvl_t rsp_level,
   output word_t    rsp_data,
   output logic     rsp_en,
   mem_wr_if.sink   wr,
   output addr_t    avs_address,
   output word_t    avs_writedata,
   output logic     avs_read,
   output logic     avs_write,
   input  word_t    avs_readdata,
   input  logic     avs_waitrequest,
   input  logic     avs_readdatavalid
);

   logic                     busy;
   logic                     wr_acc;
   logic                     rd_acc;
   logic                     done;
   rsp_lvl_t                 rd_out;
   logic [$bits(rsp_lvl_t):0] credit_used;

   // strobe high means one access is in flight
   assign busy = avs_read | avs_write;
   assign done = busy && !avs_waitrequest;

   // every read in flight needs a free response slot
   assign credit_used = {1'b0, rd_out} + {1'b0, rsp_level};

   assign wr.ready = !busy;
   assign rd_ready = !busy && !wr.valid && (credit_used < RSP_DEPTH);

   assign wr_acc = wr.valid && wr.ready;
   assign rd_acc = rd_valid && rd_ready;

   assign rsp_en   = avs_readdatavalid;
   assign rsp_data = avs_readdata;

   ////////////////////////////////////////////////////////////////////
   // strobes, held until the wait request clears
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         avs_read  <= 1'b0;
         avs_write <= 1'b0;
      end else if (wr_acc) begin
         avs_write <= 1'b1;
      end else if (rd_acc) begin
         avs_read <= 1'b1;
      end else if (done) begin
         avs_read  <= 1'b0;
         avs_write <= 1'b0;
      end
   end

   // address and write data latched at accept
   always_ff @(posedge clk) begin
      if (wr_acc) begin
         avs_address   <= wr.addr;
         avs_writedata <= wr.data;
      end else if (rd_acc) begin
         avs_address <= rd_addr;
      end
   end

   // outstanding read count
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_out <= '0;
      end else if (rd_acc && !avs_readdatavalid) begin
         rd_out <= rd_out + 1'b1;
      end else if (!rd_acc && avs_readdatavalid) begin
         rd_out <= rd_out - 1'b1;
      end
   end

   a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(avs_read && avs_write));
   // memory only returns data that was asked for
   a_rsp_expected: assert property (@(posedge clk) disable iff (reset)
      avs_readdatavalid |-> (rd_out != 0));

endmodule

/* hw/slice_walker.sv */
// ring slice address sequencer
//   first slice follows node_id, last slice of each block is node_id
//   each slice gives SLICE_WORDS consecutive word addresses
//   the walk ends with the block that reaches total_length
`timescale 1ns/100ps

module slice_walker
   import wu_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  start,
   input  logic  step,
   input  node_t node_id,
   input  node_t num_node,
   input  len_t  total_length,
   output logic  addr_valid,
   output addr_t addr
);

   logic                      active;
   addr_t                     block_base;
   addr_t                     block_words;
   node_t                     slice_idx;
   node_t                     slice_next;
   node_t                     first_slice;
   logic [LG_SLICE_WORDS-1:0] word_cnt;
   logic                      slice_end;
   logic                      block_end;
   logic                      walk_end;

   // words in one block, one slice per node
   assign block_words = addr_t'(num_node) << LG_SLICE_WORDS;

   // cyclic slice successor
   assign slice_next  = (slice_idx == num_node - 1'b1) ? '0 : slice_idx + 1'b1;
   assign first_slice = (node_id == num_node - 1'b1) ? '0 : node_id + 1'b1;

   assign slice_end = (word_cnt == LG_SLICE_WORDS'(SLICE_WORDS - 1));
   // own slice closes the block
   assign block_end = slice_end && (slice_idx == node_id);
   assign walk_end  = block_end &&
                      (len_t'(block_base) + len_t'(block_words) >= total_length);

   assign addr_valid = active;
   assign addr = block_base + (addr_t'(slice_idx) << LG_SLICE_WORDS) + addr_t'(word_cnt);

   always_ff @(posedge clk) begin
      if (reset) begin
         active     <= 1'b0;
         block_base <= '0;
         slice_idx  <= '0;
         word_cnt   <= '0;
      end else if (start) begin
         active     <= 1'b1;
         block_base <= '0;
         slice_idx  <= first_slice;
         word_cnt   <= '0;
      end else if (step && active) begin
         // word count wraps at the slice length
         word_cnt <= word_cnt + 1'b1;
         if (slice_end) begin
            slice_idx <= slice_next;
         end
         if (block_end) begin
            block_base <= block_base + block_words;
         end
         if (walk_end) begin
            active <= 1'b0;
         end
      end
   end

   // a new pass is only launched once the previous walk has drained
   a_start_idle: assert property (@(posedge clk) disable iff (reset) start |-> !active);

endmodule

/* hw/sync_fifo.sv */
// synchronous show-ahead fifo
//   circular buffer, registered fill level and almost-full flag
//   overflow and underflow checks
`timescale 1ns/100ps

module sync_fifo #(
   parameter int DW      = 8,
   parameter int DEPTH   = 16,
   parameter int ALMFULL = DEPTH
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [DW-1:0]              wr_data,
   input  logic                       wr_en,
   input  logic                       rd_en,
   output logic [DW-1:0]              rd_data,
   output logic                       empty,
   output logic                       full,
   output logic [$clog2(DEPTH+1)-1:0] level,
   output logic                       almfull
);

   localparam int PTR_W = $clog2(DEPTH);

   logic [DW-1:0]              mem [DEPTH];
   logic [PTR_W-1:0]           wr_ptr;
   logic [PTR_W-1:0]           rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] level_n;

   // head word is visible without a read cycle
   assign rd_data = mem[rd_ptr];
   assign empty   = (level == 0);
   assign full    = (level == DEPTH);

   always_comb begin
      level_n = level;
      if (wr_en && !rd_en) begin
         level_n = level + 1'b1;
      end else if (rd_en && !wr_en) begin
         level_n = level - 1'b1;
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // pointers wrap on the power-of-two depth
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         level   <= '0;
         almfull <= 1'b0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         level   <= level_n;
         almfull <= (level_n >= ALMFULL);
      end
   end

   // producers and consumers must respect the flags
   a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr_en |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty);

endmodule

/* hw/mem_wr_if.sv */
// write-request channel from the writer to the memory master
//   valid/ready handshake with a word address and one data word
`timescale 1ns/100ps

interface mem_wr_if
   import wu_pkg::*;
();

   logic  valid;
   logic  ready;
   addr_t addr;
   word_t data;

   // writer side
   modport source (output valid, output addr, output data, input ready);

   // memory master side
   modport sink (input valid, input addr, input data, output ready);

endinterface

/* hw/wu_pkg.sv */
// shared definitions for the weight updater
//   word and lane geometry, address and length types
//   slice geometry and learning-rate shift
//   fifo depths and the result back-pressure threshold
//   writer FSM states
package wu_pkg;

   // lane geometry, one memory word holds LANES fixed-point values
   localparam int LANES  = 4;
   localparam int LANE_W = 16;
   localparam int WORD_W = LANES * LANE_W;

   localparam int ADDR_W = 24;

   // slice geometry of the ring all-reduce
   localparam int LG_SLICE_WORDS = 3;
   localparam int SLICE_WORDS    = 1 << LG_SLICE_WORDS;

   // learning rate as a power of two
   localparam int LR_SHIFT = 3;

   localparam int UPDATE_LATENCY = 2;

   // buffering
   localparam int RSP_DEPTH      = 16;
   localparam int RESULT_DEPTH   = 8;
   // leave room for the words still in the update pipe
   localparam int RESULT_ALMFULL = RESULT_DEPTH - UPDATE_LATENCY - 1;

   typedef logic        [WORD_W-1:0] word_t;
   typedef logic signed [LANE_W-1:0] lane_t;
   typedef logic        [ADDR_W-1:0] addr_t;
   typedef logic        [7:0]        node_t;
   typedef logic        [31:0]       len_t;
   // fill level of the response fifo
   typedef logic [$clog2(RSP_DEPTH+1)-1:0] rsp_lvl_t;

   typedef enum logic [1:0] {
      WB_IDLE,
      WB_INIT,
      WB_UPDATE
   } wb_state_t;

endpackage
